/* logic/trace_pkg.sv */
package trace_pkg;

   // Pipeline shape
   localparam int pipe_stages  = 3;
   localparam int commit_stage = 2;

   // Queue sizing
   localparam int fifo_depth = 4;
   localparam int fifo_ptr_w = $clog2(fifo_depth);
   localparam int fifo_cnt_w = fifo_ptr_w + 1;

   // Field widths
   localparam int xlen       = 32;
   localparam int itag_w     = 8;
   localparam int reg_addr_w = 5;
   localparam int mcause_w   = 5;
   localparam int priv_w     = 2;
   localparam int cnt_w      = 16;

   typedef struct packed {
      logic                  instr_v;
      logic [itag_w-1:0]     itag;
      logic [xlen-1:0]       pc;
      logic [xlen-1:0]       instr;
      logic [reg_addr_w-1:0] rd;
   } dispatch_pkt_s;

   typedef struct packed {
      logic roll_v;
      logic poison_v;
   } stage_exc_s;

   typedef struct packed {
      logic [itag_w-1:0]     itag;
      logic [xlen-1:0]       pc;
      logic [xlen-1:0]       instr;
      logic [reg_addr_w-1:0] rd;
      logic [xlen-1:0]       result;
   } commit_rec_s;

   typedef enum logic {
      ev_trap,
      ev_ret
   } event_kind_e;

   typedef struct packed {
      event_kind_e         kind;
      logic [xlen-1:0]     pc;
      logic [mcause_w-1:0] mcause;
      logic [priv_w-1:0]   priv;
      logic [priv_w-1:0]   mpp;
      logic [cnt_w-1:0]    commit_cnt;
   } event_rec_s;

   typedef enum logic {
      src_commit,
      src_event
   } trace_src_e;

   // Commit record is the widest payload, events go zero-extended
   localparam int trace_data_w = $bits(commit_rec_s);
   localparam int event_rec_w  = $bits(event_rec_s);

   typedef struct packed {
      trace_src_e              src;
      logic [trace_data_w-1:0] data;
   } trace_word_s;

endpackage

/* logic/stage_shadow.sv */
`timescale 1ns/1ps

module stage_shadow
   import trace_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              rst_n_i,
   input  dispatch_pkt_s                     dispatch_i,
   input  stage_exc_s [pipe_stages-1:0]      exc_i,
   output dispatch_pkt_s                     commit_pkt_o
);

   dispatch_pkt_s [pipe_stages-1:0] stage_r;
   logic [pipe_stages-1:0]          squash;

   always_comb begin
      for (int i = 0; i < pipe_stages; i++) begin
         squash[i] = exc_i[i].roll_v | exc_i[i].poison_v;
      end
   end

   // Payload shifts every cycle, only the valid bits see reset
   always_ff @(posedge clk_i) begin
      stage_r[0] <= dispatch_i;
      for (int i = 1; i < pipe_stages; i++) begin
         stage_r[i]         <= stage_r[i-1];
         stage_r[i].instr_v <= stage_r[i-1].instr_v & ~squash[i-1];
      end
      if (!rst_n_i) begin
         for (int i = 0; i < pipe_stages; i++) begin
            stage_r[i].instr_v <= 1'b0;
         end
      end
   end

   // Commit-stage flags applied here; pc stays visible for event records
   always_comb begin
      commit_pkt_o         = stage_r[commit_stage];
      commit_pkt_o.instr_v = stage_r[commit_stage].instr_v & ~squash[commit_stage];
   end

endmodule

/* logic/commit_tracer.sv */
`timescale 1ns/1ps

module commit_tracer
   import trace_pkg::*;
(
   input  logic            clk_i,
   input  logic            rst_n_i,
   input  dispatch_pkt_s   commit_pkt_i,
   input  logic [xlen-1:0] iwb_result_i,
   output commit_rec_s     rec_o,
   output logic            push_o,
   output logic            commit_pulse_o
);

   commit_rec_s rec_r;
   logic        push_r;

   always_ff @(posedge clk_i) begin
      if (commit_pkt_i.instr_v) begin
         rec_r.itag   <= commit_pkt_i.itag;
         rec_r.pc     <= commit_pkt_i.pc;
         rec_r.instr  <= commit_pkt_i.instr;
         rec_r.rd     <= commit_pkt_i.rd;
         rec_r.result <= iwb_result_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         push_r <= 1'b0;
      end else begin
         push_r <= commit_pkt_i.instr_v;
      end
   end

   assign rec_o          = rec_r;
   assign push_o         = push_r;
   assign commit_pulse_o = push_r;

endmodule

/* logic/event_tracer.sv */
`timescale 1ns/1ps

module event_tracer
   import trace_pkg::*;
(
   input  logic                clk_i,
   input  logic                rst_n_i,
   input  logic [xlen-1:0]     commit_pc_i,
   input  logic                commit_pulse_i,
   input  logic                trap_v_i,
   input  logic                ret_v_i,
   input  logic [mcause_w-1:0] mcause_i,
   input  logic [priv_w-1:0]   priv_i,
   input  logic [priv_w-1:0]   mpp_i,
   output event_rec_s          rec_o,
   output logic                push_o
);

   logic [cnt_w-1:0] cnt_r;
   logic [cnt_w-1:0] cnt_inc;
   logic             ev_v;
   event_rec_s       rec_r;
   logic             push_r;

   assign ev_v = trap_v_i | ret_v_i;

   // Saturates instead of wrapping
   assign cnt_inc = (commit_pulse_i && (cnt_r != '1)) ? cnt_r + 1'b1 : cnt_r;

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         cnt_r  <= '0;
         push_r <= 1'b0;
      end else begin
         cnt_r  <= ev_v ? '0 : cnt_inc;
         push_r <= ev_v;
      end
   end

   always_ff @(posedge clk_i) begin
      if (ev_v) begin
         rec_r.kind       <= trap_v_i ? ev_trap : ev_ret;
         rec_r.pc         <= commit_pc_i;
         rec_r.mcause     <= mcause_i;
         rec_r.priv       <= priv_i;
         rec_r.mpp        <= mpp_i;
         rec_r.commit_cnt <= cnt_inc;
      end
   end

   assign rec_o  = rec_r;
   assign push_o = push_r;

endmodule

/* logic/trace_fifo.sv */
`timescale 1ns/1ps

module trace_fifo
   import trace_pkg::*;
#(
   parameter type payload_t = commit_rec_s
)
(
   input  logic     clk_i,
   input  logic     rst_n_i,
   input  logic     push_i,
   input  payload_t data_i,
   input  logic     pop_i,
   output payload_t data_o,
   output logic     not_empty_o,
   output logic     overflow_o
);

   payload_t [fifo_depth-1:0] mem_r;
   logic [fifo_ptr_w-1:0]     wr_ptr_r;
   logic [fifo_ptr_w-1:0]     rd_ptr_r;
   logic [fifo_cnt_w-1:0]     count_r;
   logic                      full;
   logic                      push_ok;
   logic                      pop_ok;
   logic                      ovf_r;

   assign full    = (count_r == fifo_cnt_w'(fifo_depth));
   assign push_ok = push_i && !full;
   assign pop_ok  = pop_i && (count_r != '0);

   always_ff @(posedge clk_i) begin
      if (push_ok) begin
         mem_r[wr_ptr_r] <= data_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         wr_ptr_r <= '0;
         rd_ptr_r <= '0;
         count_r  <= '0;
         ovf_r    <= 1'b0;
      end else begin
         if (push_ok) begin
            wr_ptr_r <= (wr_ptr_r == fifo_ptr_w'(fifo_depth - 1)) ? '0 : wr_ptr_r + 1'b1;
         end
         if (pop_ok) begin
            rd_ptr_r <= (rd_ptr_r == fifo_ptr_w'(fifo_depth - 1)) ? '0 : rd_ptr_r + 1'b1;
         end
         count_r <= count_r + fifo_cnt_w'(push_ok) - fifo_cnt_w'(pop_ok);
         // Dropped push, flag stays until reset
         if (push_i && full) begin
            ovf_r <= 1'b1;
         end
      end
   end

   assign data_o      = mem_r[rd_ptr_r];
   assign not_empty_o = (count_r != '0);
   assign overflow_o  = ovf_r;

endmodule

/* logic/trace_arbiter.sv */
`timescale 1ns/1ps

module trace_arbiter
   import trace_pkg::*;
(
   input  logic        clk_i,
   input  logic        rst_n_i,
   input  commit_rec_s commit_head_i,
   input  logic        commit_ne_i,
   input  event_rec_s  event_head_i,
   input  logic        event_ne_i,
   output logic        commit_pop_o,
   output logic        event_pop_o,
   output trace_word_s trace_o,
   output logic        trace_req_o,
   input  logic        trace_ack_i
);

   typedef enum logic [1:0] {
      st_idle,
      st_req,
      st_release
   } arb_state_e;

   arb_state_e  state_r;
   trace_src_e  last_r;
   trace_src_e  pick;
   trace_word_s word_r;
   trace_word_s word_next;
   logic        start;
   logic        pop;

   // Ack must be low before a new request goes out
   assign start = (state_r == st_idle) && !trace_ack_i && (commit_ne_i || event_ne_i);

   always_comb begin
      if (commit_ne_i && event_ne_i) begin
         pick = (last_r == src_commit) ? src_event : src_commit;
      end else if (event_ne_i) begin
         pick = src_event;
      end else begin
         pick = src_commit;
      end
   end

   always_comb begin
      word_next     = '0;
      word_next.src = pick;
      if (pick == src_event) begin
         word_next.data[event_rec_w-1:0] = event_head_i;
      end else begin
         word_next.data = commit_head_i;
      end
   end

   always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
         state_r <= st_idle;
         last_r  <= src_event;
      end else begin
         case (state_r)
            st_idle: begin
               if (start) begin
                  state_r <= st_req;
                  last_r  <= pick;
               end
            end
            st_req: begin
               if (trace_ack_i) begin
                  state_r <= st_release;
               end
            end
            st_release: begin
               if (!trace_ack_i) begin
                  state_r <= st_idle;
               end
            end
            default: state_r <= st_idle;
         endcase
      end
   end

   // Held stable for the whole request
   always_ff @(posedge clk_i) begin
      if (start) begin
         word_r <= word_next;
      end
   end

   assign pop          = (state_r == st_req) && trace_ack_i;
   assign commit_pop_o = pop && (word_r.src == src_commit);
   assign event_pop_o  = pop && (word_r.src == src_event);
   assign trace_o      = word_r;
   assign trace_req_o  = (state_r == st_req);

endmodule

/* logic/trace_top.sv */
`timescale 1ns/1ps

module trace_top
   import trace_pkg::*;
(
   input  logic                         clk_i,
   input  logic                         rst_n_i,
   input  dispatch_pkt_s                dispatch_i,
   input  stage_exc_s [pipe_stages-1:0] exc_i,
   input  logic [xlen-1:0]              iwb_result_i,
   input  logic                         trap_v_i,
   input  logic                         ret_v_i,
   input  logic [mcause_w-1:0]          mcause_i,
   input  logic [priv_w-1:0]            priv_i,
   input  logic [priv_w-1:0]            mpp_i,
   output trace_word_s                  trace_o,
   output logic                         trace_req_o,
   input  logic                         trace_ack_i,
   output logic                         overflow_o
);

   dispatch_pkt_s commit_pkt;
   commit_rec_s   commit_rec;
   commit_rec_s   commit_head;
   event_rec_s    event_rec;
   event_rec_s    event_head;
   logic          commit_push;
   logic          commit_pulse;
   logic          event_push;
   logic          commit_ne;
   logic          event_ne;
   logic          commit_pop;
   logic          event_pop;
   logic          commit_ovf;
   logic          event_ovf;

   stage_shadow shadow (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .dispatch_i   (dispatch_i),
      .exc_i        (exc_i),
      .commit_pkt_o (commit_pkt)
   );

   commit_tracer cmt_tr (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .commit_pkt_i   (commit_pkt),
      .iwb_result_i   (iwb_result_i),
      .rec_o          (commit_rec),
      .push_o         (commit_push),
      .commit_pulse_o (commit_pulse)
   );

   event_tracer ev_tr (
      .clk_i          (clk_i),
      .rst_n_i        (rst_n_i),
      .commit_pc_i    (commit_pkt.pc),
      .commit_pulse_i (commit_pulse),
      .trap_v_i       (trap_v_i),
      .ret_v_i        (ret_v_i),
      .mcause_i       (mcause_i),
      .priv_i         (priv_i),
      .mpp_i          (mpp_i),
      .rec_o          (event_rec),
      .push_o         (event_push)
   );

   trace_fifo #(.payload_t(commit_rec_s)) commit_q (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (commit_push),
      .data_i      (commit_rec),
      .pop_i       (commit_pop),
      .data_o      (commit_head),
      .not_empty_o (commit_ne),
      .overflow_o  (commit_ovf)
   );

   trace_fifo #(.payload_t(event_rec_s)) event_q (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .push_i      (event_push),
      .data_i      (event_rec),
      .pop_i       (event_pop),
      .data_o      (event_head),
      .not_empty_o (event_ne),
      .overflow_o  (event_ovf)
   );

   trace_arbiter arb (
      .clk_i         (clk_i),
      .rst_n_i       (rst_n_i),
      .commit_head_i (commit_head),
      .commit_ne_i   (commit_ne),
      .event_head_i  (event_head),
      .event_ne_i    (event_ne),
      .commit_pop_o  (commit_pop),
      .event_pop_o   (event_pop),
      .trace_o       (trace_o),
      .trace_req_o   (trace_req_o),
      .trace_ack_i   (trace_ack_i)
   );

   assign overflow_o = commit_ovf | event_ovf;

endmodule

/* tb/tb_trace_top.sv */
`timescale 1ns/1ps

module tb_trace_top
   import trace_pkg::*;
;

   logic                         clk_i;
   logic                         rst_n_i;
   dispatch_pkt_s                dispatch_i;
   stage_exc_s [pipe_stages-1:0] exc_i;
   logic [xlen-1:0]              iwb_result_i;
   logic                         trap_v_i;
   logic                         ret_v_i;
   logic [mcause_w-1:0]          mcause_i;
   logic [priv_w-1:0]            priv_i;
   logic [priv_w-1:0]            mpp_i;
   trace_word_s                  trace_o;
   logic                         trace_req_o;
   logic                         trace_ack_i;
   logic                         overflow_o;

   integer seed     = 32'h9d91;
   integer ack_seed = 32'h9d91 ^ 32'h5a5a;
   int     errors;
   int     passes;
   int     rx_count;
   int     commits_since;
   int     ack_delay;
   logic   hold_ack;
   logic [itag_w-1:0] next_tag;

   // Expected view of the shadow stages with index 2 at commit
   dispatch_pkt_s   mdl_pkt [pipe_stages];
   logic [xlen-1:0] mdl_res [pipe_stages];
   trace_word_s     exp_commit[$];
   trace_word_s     exp_event[$];

   trace_top uut (.*);

   initial begin
      clk_i = 1'b0;
      forever #20 clk_i = ~clk_i;
   end

   function automatic commit_rec_s expect_commit(input dispatch_pkt_s p,
                                                 input logic [xlen-1:0] res);
      commit_rec_s r;
      r.itag   = p.itag;
      r.pc     = p.pc;
      r.instr  = p.instr;
      r.rd     = p.rd;
      r.result = res;
      return r;
   endfunction

   function automatic event_rec_s expect_event(input logic trap, input logic [xlen-1:0] pc,
                                               input logic [mcause_w-1:0] mcause,
                                               input logic [priv_w-1:0] priv,
                                               input logic [priv_w-1:0] mpp, input int cnt);
      event_rec_s r;
      r.kind       = trap ? ev_trap : ev_ret;
      r.pc         = pc;
      r.mcause     = mcause;
      r.priv       = priv;
      r.mpp        = mpp;
      r.commit_cnt = (cnt > 65535) ? '1 : cnt_w'(cnt);
      return r;
   endfunction

   function automatic trace_word_s commit_word(input commit_rec_s r);
      trace_word_s w;
      w.src  = src_commit;
      w.data = r;
      return w;
   endfunction

   function automatic trace_word_s event_word(input event_rec_s r);
      trace_word_s w;
      w                       = '0;
      w.src                   = src_event;
      w.data[event_rec_w-1:0] = r;
      return w;
   endfunction

   // Commit records still owed including those in flight
   function automatic int in_flight();
      int n;
      n = exp_commit.size();
      for (int s = 0; s < pipe_stages; s++) begin
         if (mdl_pkt[s].instr_v) n++;
      end
      return n;
   endfunction

   // One cycle of stimulus with the expected records it implies
   task automatic run_cycle(input logic v, input stage_exc_s [pipe_stages-1:0] exc,
                            input logic trap, input logic ret);
      logic [pipe_stages-1:0] sq;
      logic                   commit_now;
      dispatch_pkt_s          pkt;
      logic [xlen-1:0]        res;
      @(negedge clk_i);
      pkt.instr_v = v;
      pkt.itag    = next_tag;
      pkt.pc      = {(xlen-2)'($random(seed)), 2'b00};
      pkt.instr   = xlen'($random(seed));
      pkt.rd      = reg_addr_w'($random(seed));
      res         = xlen'($random(seed));
      if (v) next_tag = next_tag + 1'b1;
      for (int s = 0; s < pipe_stages; s++) begin
         sq[s] = exc[s].roll_v | exc[s].poison_v;
      end
      dispatch_i   = pkt;
      exc_i        = exc;
      trap_v_i     = trap;
      ret_v_i      = ret;
      mcause_i     = mcause_w'($random(seed));
      priv_i       = priv_w'($random(seed));
      mpp_i        = priv_w'($random(seed));
      iwb_result_i = mdl_pkt[2].instr_v ? mdl_res[2] : xlen'($random(seed));
      commit_now   = mdl_pkt[2].instr_v && !sq[2];
      if (trap || ret) begin
         exp_event.push_back(event_word(expect_event(trap, mdl_pkt[2].pc, mcause_i,
                                                     priv_i, mpp_i, commits_since)));
         commits_since = 0;
      end
      if (commit_now) begin
         exp_commit.push_back(commit_word(expect_commit(mdl_pkt[2], mdl_res[2])));
         commits_since++;
      end
      mdl_pkt[2]         = mdl_pkt[1];
      mdl_pkt[2].instr_v = mdl_pkt[1].instr_v & ~sq[1];
      mdl_res[2]         = mdl_res[1];
      mdl_pkt[1]         = mdl_pkt[0];
      mdl_pkt[1].instr_v = mdl_pkt[0].instr_v & ~sq[0];
      mdl_res[1]         = mdl_res[0];
      mdl_pkt[0]         = pkt;
      mdl_res[0]         = res;
   endtask

   task automatic drain_queues(input string what);
      int n;
      n = 0;
      while ((exp_commit.size() != 0 || exp_event.size() != 0 || in_flight() != 0)
             && n < 300) begin
         run_cycle(1'b0, '0, 1'b0, 1'b0);
         n++;
      end
      if (n >= 300) begin
         $display("Timeout at %0t: %s records still missing (%0d commit, %0d event)",
                  $time, what, exp_commit.size(), exp_event.size());
         errors++;
      end
      // Quiet tail so a surplus record still reaches the compare process
      for (int k = 0; k < 12; k++) begin
         run_cycle(1'b0, '0, 1'b0, 1'b0);
      end
   endtask

   task automatic set_hold(input logic v);
      @(posedge clk_i);
      hold_ack = v;
   endtask

   task automatic report_test(input string name, input int err_at_start);
      $display("[%0t] %s finished, %0d errors", $time, name, errors - err_at_start);
   endtask

   function automatic int squash_stage(input int j);
      case (j)
         1:       return 0;
         3:       return 1;
         4:       return 2;
         default: return pipe_stages;
      endcase
   endfunction

   // Host side of the req/ack handshake
   always @(negedge clk_i) begin
      if (!rst_n_i) begin
         trace_ack_i = 1'b0;
      end else if (trace_req_o && !trace_ack_i && !hold_ack) begin
         if (ack_delay == 0) begin
            trace_ack_i = 1'b1;
         end else begin
            ack_delay = ack_delay - 1;
         end
      end else if (!trace_req_o && trace_ack_i) begin
         trace_ack_i = 1'b0;
         ack_delay   = $random(ack_seed) & 3;
      end
   end

   always @(posedge clk_i) begin : compare_words
      trace_word_s exp_w;
      if (rst_n_i && trace_req_o && trace_ack_i) begin
         rx_count++;
         if (trace_o.src == src_commit && exp_commit.size() == 0) begin
            $display("Unexpected commit record at %0t", $time);
            errors++;
         end else if (trace_o.src == src_event && exp_event.size() == 0) begin
            $display("Unexpected event record at %0t", $time);
            errors++;
         end else begin
            exp_w = (trace_o.src == src_commit) ? exp_commit.pop_front()
                                                : exp_event.pop_front();
            if (trace_o !== exp_w) begin
               $display("ERROR %0t trace_o expected %h got %h", $time, exp_w, trace_o);
               errors++;
            end else begin
               passes++;
            end
         end
      end
   end

   initial begin
      stage_exc_s [pipe_stages-1:0] exc;
      int   j;
      int   err0;
      int   rx0;
      logic go;
      logic ev;
      logic trap;
      logic ret;
      errors        = 0;
      passes        = 0;
      rx_count      = 0;
      commits_since = 0;
      ack_delay     = 0;
      hold_ack      = 1'b0;
      next_tag      = '0;
      rst_n_i       = 1'b0;
      dispatch_i    = '0;
      exc_i         = '0;
      iwb_result_i  = '0;
      trap_v_i      = 1'b0;
      ret_v_i       = 1'b0;
      mcause_i      = '0;
      priv_i        = '0;
      mpp_i         = '0;
      trace_ack_i   = 1'b0;
      for (int s = 0; s < pipe_stages; s++) begin
         mdl_pkt[s] = '0;
         mdl_res[s] = '0;
      end
      repeat (16) @(negedge clk_i);
      rst_n_i = 1'b1;

      err0 = errors;
      for (int k = 0; k < 20; k++) begin
         run_cycle(1'b0, '0, 1'b0, 1'b0);
         if (trace_req_o !== 1'b0 || overflow_o !== 1'b0) begin
            $display("ERROR %0t trace_req_o/overflow_o expected 0/0 got %b/%b",
                     $time, trace_req_o, overflow_o);
            errors++;
         end
      end
      report_test("idle after reset", err0);

      err0 = errors;
      for (int k = 0; k < 5; k++) run_cycle(1'b1, '0, 1'b0, 1'b0);
      drain_queues("in-order commit");
      report_test("in-order commits", err0);

      // Squash one packet at each stage by roll or poison
      err0 = errors;
      for (int k = 0; k < 9; k++) begin
         exc = '0;
         for (int s = 0; s < pipe_stages; s++) begin
            j = k - 1 - s;
            if (j >= 0 && j < 6 && squash_stage(j) == s) begin
               if (j[0]) exc[s].poison_v = 1'b1;
               else exc[s].roll_v = 1'b1;
            end
         end
         run_cycle(k < 6, exc, 1'b0, 1'b0);
      end
      drain_queues("squash");
      report_test("squashed entries", err0);

      err0 = errors;
      for (int k = 0; k < 3; k++) run_cycle(1'b1, '0, 1'b0, 1'b0);
      run_cycle(1'b0, '0, 1'b1, 1'b0);
      run_cycle(1'b1, '0, 1'b0, 1'b0);
      run_cycle(1'b0, '0, 1'b0, 1'b0);
      run_cycle(1'b0, '0, 1'b0, 1'b1);
      run_cycle(1'b0, '0, 1'b0, 1'b0);
      run_cycle(1'b0, '0, 1'b1, 1'b1);
      drain_queues("event");
      report_test("trap and return events", err0);

      // Issue is throttled so the queues never fill
      err0 = errors;
      for (int k = 0; k < 300; k++) begin
         exc = '0;
         for (int s = 0; s < pipe_stages; s++) begin
            exc[s].roll_v   = (($random(seed) & 15) == 0);
            exc[s].poison_v = (($random(seed) & 15) == 1);
         end
         go   = (($random(seed) & 1) == 1) && (in_flight() < 3);
         ev   = (($random(seed) & 15) == 0) && (exp_event.size() < 3);
         trap = ev && (($random(seed) & 1) == 1);
         ret  = ev && (!trap || (($random(seed) & 1) == 1));
         run_cycle(go, exc, trap, ret);
      end
      drain_queues("random mix");
      if (overflow_o !== 1'b0) begin
         $display("ERROR %0t overflow_o expected 0 got %b", $time, overflow_o);
         errors++;
      end
      report_test("random mix", err0);

      err0 = errors;
      set_hold(1'b1);
      for (int k = 0; k < 10; k++) run_cycle(1'b1, '0, 1'b0, 1'b0);
      for (int k = 0; k < 6; k++) run_cycle(1'b0, '0, 1'b0, 1'b0);
      if (overflow_o !== 1'b1) begin
         $display("ERROR %0t overflow_o expected 1 got %b", $time, overflow_o);
         errors++;
      end
      // Only the oldest records fit and later pushes are dropped
      while (exp_commit.size() > fifo_depth) void'(exp_commit.pop_back());
      rx0 = rx_count;
      set_hold(1'b0);
      drain_queues("overflow");
      if (rx_count - rx0 != fifo_depth) begin
         $display("ERROR %0t records after release expected %0d got %0d",
                  $time, fifo_depth, rx_count - rx0);
         errors++;
      end
      report_test("overflow with ack withheld", err0);

      $display("Checks passed: %0d, errors: %0d", passes, errors);
      if (errors == 0) begin
         $display("TEST PASS");
      end else begin
         $display("TEST FAIL");
      end
      $finish;
   end

endmodule

/* sources.f */
logic/trace_pkg.sv
logic/stage_shadow.sv
logic/commit_tracer.sv
logic/event_tracer.sv
logic/trace_fifo.sv
logic/trace_arbiter.sv
logic/trace_top.sv
tb/tb_trace_top.sv

/* Makefile */
# Verilator build and run of the trace unit testbench

VERILATOR ?= verilator
TOP       ?= tb_trace_top
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

$(BUILD_DIR)/$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)

test: $(BUILD_DIR)/$(TOP)
	./$(BUILD_DIR)/$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "^TEST PASS$$" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
